//--- gnn_debug_macros.svh
`ifndef GNN_DEBUG_MACROS_SVH
`define GNN_DEBUG_MACROS_SVH

// Stage indices are 0 spmm, 1 dmvm, 2 sm, 3 aggr
`define DBG_NUM_STAGES         4
`define DBG_CNT_W              32

`define DBG_FEAT_ADDR_W        16
`define DBG_FEAT_DATA_W        32
`define DBG_FEAT_HIGH_LIMIT    43328   // First address that counts as a high write

`define DBG_H_NUM_SPARSE_DATA  12

`define DBG_AXIL_ADDR_W        6
`define DBG_AXIL_DATA_W        32
`define DBG_RESP_OKAY          2'b00
`define DBG_RESP_SLVERR        2'b10

`define DBG_REG_CONFIG         6'h00
`define DBG_REG_STATUS         6'h04
`define DBG_REG_CONTROL        6'h08
`define DBG_REG_WATCH0         6'h0C
`define DBG_REG_WATCH1         6'h10
`define DBG_REG_CAPTURE0       6'h14
`define DBG_REG_CAPTURE1       6'h18
`define DBG_REG_XFER0          6'h1C
`define DBG_REG_XFER1          6'h20
`define DBG_REG_XFER2          6'h24
`define DBG_REG_XFER3          6'h28

`define DBG_WATCH0_RST         1
`define DBG_WATCH1_RST         2

`endif

//--- gnn_debug_pkg.sv
`include "gnn_debug_macros.svh"

package gnn_debug_pkg;

  // One bit per monitored stage
  typedef logic [`DBG_NUM_STAGES-1:0] stage_mask_t;

  typedef logic [`DBG_CNT_W-1:0] xfer_count_t;

  typedef xfer_count_t [`DBG_NUM_STAGES-1:0] xfer_array_t;

  // Layout of the STATUS register, LSB last
  typedef struct packed {
    logic [`DBG_AXIL_DATA_W-2*`DBG_NUM_STAGES-3:0] rsvd;
    logic                                         feat_high_seen;
    logic                                         feat_ena_seen;
    stage_mask_t                                  rdy_seen;
    stage_mask_t                                  vld_seen;
  } dbg_status_t;

endpackage

//--- dbg_probe_if.sv
`timescale 1ns/1ps
`include "gnn_debug_macros.svh"

interface dbg_probe_if;
  import gnn_debug_pkg::*;

  // Stage monitor results
  stage_mask_t stage_vld_seen;
  stage_mask_t stage_rdy_seen;
  xfer_array_t xfer_count;

  // Feature BRAM snoop results
  logic                  feat_ena_seen;
  logic                  feat_high_seen;
  logic [`DBG_CNT_W-1:0] capture0;
  logic [`DBG_CNT_W-1:0] capture1;

  // Control from the register block
  logic                        clear;
  logic [`DBG_FEAT_ADDR_W-1:0] watch0_addr;
  logic [`DBG_FEAT_ADDR_W-1:0] watch1_addr;

  modport stage_mp (
    output stage_vld_seen, stage_rdy_seen, xfer_count,
    input  clear
  );

  modport snoop_mp (
    output feat_ena_seen, feat_high_seen, capture0, capture1,
    input  clear, watch0_addr, watch1_addr
  );

  modport csr_mp (
    input  stage_vld_seen, stage_rdy_seen, xfer_count,
    input  feat_ena_seen, feat_high_seen, capture0, capture1,
    output clear, watch0_addr, watch1_addr
  );

endinterface

//--- stage_activity_monitor.sv
`timescale 1ns/1ps
`include "gnn_debug_macros.svh"

module stage_activity_monitor (
  input  logic                       clk,
  input  logic                       rst_n,
  input  gnn_debug_pkg::stage_mask_t stage_vld_i,
  input  gnn_debug_pkg::stage_mask_t stage_rdy_i,
  dbg_probe_if.stage_mp              probe
);
  import gnn_debug_pkg::*;

  stage_mask_t vld_seen_q;
  stage_mask_t rdy_seen_q;
  stage_mask_t xfer_hit;
  xfer_array_t xfer_q;

  // A transfer completes on any edge where both sides agree
  assign xfer_hit = stage_vld_i & stage_rdy_i;

  // Once a stage has raised valid or ready the flag holds until cleared
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_seen_q <= '0;
      rdy_seen_q <= '0;
    end else if (probe.clear) begin
      vld_seen_q <= '0;
      rdy_seen_q <= '0;
    end else begin
      vld_seen_q <= vld_seen_q | stage_vld_i;
      rdy_seen_q <= rdy_seen_q | stage_rdy_i;
    end
  end

  // Counters wrap at all ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      xfer_q <= '0;
    end else if (probe.clear) begin
      xfer_q <= '0; // Clear wins over a transfer on the same edge
    end else begin
      for (int s = 0; s < `DBG_NUM_STAGES; s++) begin
        if (xfer_hit[s]) begin
          xfer_q[s] <= xfer_q[s] + 1'b1;
        end
      end
    end
  end

  assign probe.stage_vld_seen = vld_seen_q;
  assign probe.stage_rdy_seen = rdy_seen_q;
  assign probe.xfer_count     = xfer_q;

endmodule

//--- feat_write_snooper.sv
`timescale 1ns/1ps
`include "gnn_debug_macros.svh"

module feat_write_snooper (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`DBG_FEAT_DATA_W-1:0] feat_bram_din_i,
  input  logic                        feat_bram_ena_i,
  input  logic [`DBG_FEAT_ADDR_W-1:0] feat_bram_addra_i,
  dbg_probe_if.snoop_mp               probe
);

  logic                  ena_seen_q;
  logic                  high_seen_q;
  logic [`DBG_CNT_W-1:0] capture0_q;
  logic [`DBG_CNT_W-1:0] capture1_q;
  logic                  high_hit;
  logic                  watch0_hit;
  logic                  watch1_hit;

  // Disabled writes never count, even at a high address
  assign high_hit   = feat_bram_ena_i && (feat_bram_addra_i >= `DBG_FEAT_HIGH_LIMIT);
  assign watch0_hit = feat_bram_ena_i && (feat_bram_addra_i == probe.watch0_addr);
  assign watch1_hit = feat_bram_ena_i && (feat_bram_addra_i == probe.watch1_addr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ena_seen_q  <= 1'b0;
      high_seen_q <= 1'b0;
    end else if (probe.clear) begin
      ena_seen_q  <= 1'b0;
      high_seen_q <= 1'b0;
    end else begin
      ena_seen_q  <= ena_seen_q | feat_bram_ena_i;
      high_seen_q <= high_seen_q | high_hit;
    end
  end

  // Equal watch addresses load both captures from the same write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      capture0_q <= '0;
      capture1_q <= '0;
    end else if (probe.clear) begin
      capture0_q <= '0;
      capture1_q <= '0;
    end else begin
      if (watch0_hit) begin
        capture0_q <= feat_bram_din_i; // Last write to the address wins
      end
      if (watch1_hit) begin
        capture1_q <= feat_bram_din_i;
      end
    end
  end

  assign probe.feat_ena_seen  = ena_seen_q;
  assign probe.feat_high_seen = high_seen_q;
  assign probe.capture0       = capture0_q;
  assign probe.capture1       = capture1_q;

endmodule

//--- debug_csr_axil.sv
`timescale 1ns/1ps
`include "gnn_debug_macros.svh"

module debug_csr_axil (
  input  logic                          clk,
  input  logic                          rst_n,
  // Write address channel
  input  logic [`DBG_AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
  input  logic                          s_axil_awvalid_i,
  output logic                          s_axil_awready_o,
  // Write data channel
  input  logic [`DBG_AXIL_DATA_W-1:0]   s_axil_wdata_i,
  input  logic [`DBG_AXIL_DATA_W/8-1:0] s_axil_wstrb_i,
  input  logic                          s_axil_wvalid_i,
  output logic                          s_axil_wready_o,
  // Write response channel
  output logic [1:0]                    s_axil_bresp_o,
  output logic                          s_axil_bvalid_o,
  input  logic                          s_axil_bready_i,
  // Read address channel
  input  logic [`DBG_AXIL_ADDR_W-1:0]   s_axil_araddr_i,
  input  logic                          s_axil_arvalid_i,
  output logic                          s_axil_arready_o,
  // Read data channel
  output logic [`DBG_AXIL_DATA_W-1:0]   s_axil_rdata_o,
  output logic [1:0]                    s_axil_rresp_o,
  output logic                          s_axil_rvalid_o,
  input  logic                          s_axil_rready_i,
  dbg_probe_if.csr_mp                   probe
);
  import gnn_debug_pkg::*;

  logic                        wr_accept;
  logic                        rd_accept;
  logic                        bvalid_q;
  logic [1:0]                  bresp_q;
  logic                        rvalid_q;
  logic [1:0]                  rresp_q;
  logic [`DBG_AXIL_DATA_W-1:0] rdata_q;
  logic [`DBG_AXIL_DATA_W-1:0] rd_data;
  logic [1:0]                  rd_resp;
  logic                        clear_q;
  logic [`DBG_FEAT_ADDR_W-1:0] watch0_q;
  logic [`DBG_FEAT_ADDR_W-1:0] watch1_q;
  dbg_status_t                 status_word;

  function automatic logic addr_mapped(input logic [`DBG_AXIL_ADDR_W-1:0] addr);
    case (addr)
      `DBG_REG_CONFIG, `DBG_REG_STATUS, `DBG_REG_CONTROL,
      `DBG_REG_WATCH0, `DBG_REG_WATCH1,
      `DBG_REG_CAPTURE0, `DBG_REG_CAPTURE1,
      `DBG_REG_XFER0, `DBG_REG_XFER1, `DBG_REG_XFER2, `DBG_REG_XFER3:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  // Address and data are taken together, only while no response waits
  assign wr_accept        = s_axil_awvalid_i && s_axil_wvalid_i && !bvalid_q;
  assign s_axil_awready_o = wr_accept;
  assign s_axil_wready_o  = wr_accept;

  assign rd_accept        = s_axil_arvalid_i && !rvalid_q;
  assign s_axil_arready_o = !rvalid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
      clear_q  <= 1'b0;
      watch0_q <= `DBG_FEAT_ADDR_W'(`DBG_WATCH0_RST);
      watch1_q <= `DBG_FEAT_ADDR_W'(`DBG_WATCH1_RST);
    end else begin
      clear_q <= 1'b0; // Clear is a single-cycle pulse aligned with BVALID rising
      if (wr_accept) begin
        bvalid_q <= 1'b1;
        case (s_axil_awaddr_i)
          `DBG_REG_CONTROL: clear_q <= s_axil_wdata_i[0];
          `DBG_REG_WATCH0: begin
            for (int b = 0; b < `DBG_FEAT_ADDR_W/8; b++) begin
              if (s_axil_wstrb_i[b]) begin
                watch0_q[b*8 +: 8] <= s_axil_wdata_i[b*8 +: 8];
              end
            end
          end
          `DBG_REG_WATCH1: begin
            for (int b = 0; b < `DBG_FEAT_ADDR_W/8; b++) begin
              if (s_axil_wstrb_i[b]) begin
                watch1_q[b*8 +: 8] <= s_axil_wdata_i[b*8 +: 8];
              end
            end
          end
          default: ; // Read-only and unmapped writes have no effect
        endcase
      end else if (s_axil_bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      bresp_q <= addr_mapped(s_axil_awaddr_i) ? `DBG_RESP_OKAY : `DBG_RESP_SLVERR;
    end
  end

  always_comb begin
    status_word                = '0;
    status_word.vld_seen       = probe.stage_vld_seen;
    status_word.rdy_seen       = probe.stage_rdy_seen;
    status_word.feat_ena_seen  = probe.feat_ena_seen;
    status_word.feat_high_seen = probe.feat_high_seen;
  end

  always_comb begin
    rd_data = '0;
    rd_resp = `DBG_RESP_OKAY;
    case (s_axil_araddr_i)
      `DBG_REG_CONFIG:   rd_data = `DBG_AXIL_DATA_W'(`DBG_H_NUM_SPARSE_DATA);
      `DBG_REG_STATUS:   rd_data = status_word;
      `DBG_REG_CONTROL:  rd_data = '0;  // Write-only
      `DBG_REG_WATCH0:   rd_data = `DBG_AXIL_DATA_W'(watch0_q);
      `DBG_REG_WATCH1:   rd_data = `DBG_AXIL_DATA_W'(watch1_q);
      `DBG_REG_CAPTURE0: rd_data = probe.capture0;
      `DBG_REG_CAPTURE1: rd_data = probe.capture1;
      `DBG_REG_XFER0:    rd_data = probe.xfer_count[0];
      `DBG_REG_XFER1:    rd_data = probe.xfer_count[1];
      `DBG_REG_XFER2:    rd_data = probe.xfer_count[2];
      `DBG_REG_XFER3:    rd_data = probe.xfer_count[3];
      default:           rd_resp = `DBG_RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else if (rd_accept) begin
      rvalid_q <= 1'b1;
    end else if (s_axil_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  // Data is sampled at the AR handshake and held until RREADY
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  assign s_axil_bvalid_o = bvalid_q;
  assign s_axil_bresp_o  = bresp_q;
  assign s_axil_rvalid_o = rvalid_q;
  assign s_axil_rresp_o  = rresp_q;
  assign s_axil_rdata_o  = rdata_q;

  assign probe.clear       = clear_q;
  assign probe.watch0_addr = watch0_q;
  assign probe.watch1_addr = watch1_q;

endmodule

//--- gnn_debug_top.sv
`timescale 1ns/1ps
`include "gnn_debug_macros.svh"

module gnn_debug_top (
  input  logic                          clk,
  input  logic                          rst_n,
  // Stage handshake probes
  input  logic                          spmm_vld_i,
  input  logic                          spmm_rdy_i,
  input  logic                          dmvm_vld_i,
  input  logic                          dmvm_rdy_i,
  input  logic                          sm_vld_i,
  input  logic                          sm_rdy_i,
  input  logic                          aggr_vld_i,
  input  logic                          aggr_rdy_i,
  // Feature BRAM write port snoop
  input  logic [`DBG_FEAT_DATA_W-1:0]   feat_bram_din_i,
  input  logic                          feat_bram_ena_i,
  input  logic [`DBG_FEAT_ADDR_W-1:0]   feat_bram_addra_i,
  // AXI4-Lite slave
  input  logic [`DBG_AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
  input  logic                          s_axil_awvalid_i,
  output logic                          s_axil_awready_o,
  input  logic [`DBG_AXIL_DATA_W-1:0]   s_axil_wdata_i,
  input  logic [`DBG_AXIL_DATA_W/8-1:0] s_axil_wstrb_i,
  input  logic                          s_axil_wvalid_i,
  output logic                          s_axil_wready_o,
  output logic [1:0]                    s_axil_bresp_o,
  output logic                          s_axil_bvalid_o,
  input  logic                          s_axil_bready_i,
  input  logic [`DBG_AXIL_ADDR_W-1:0]   s_axil_araddr_i,
  input  logic                          s_axil_arvalid_i,
  output logic                          s_axil_arready_o,
  output logic [`DBG_AXIL_DATA_W-1:0]   s_axil_rdata_o,
  output logic [1:0]                    s_axil_rresp_o,
  output logic                          s_axil_rvalid_o,
  input  logic                          s_axil_rready_i
);
  import gnn_debug_pkg::*;

  stage_mask_t stage_vld;
  stage_mask_t stage_rdy;

  // Bit order follows the stage indices spmm, dmvm, sm, aggr
  assign stage_vld = {aggr_vld_i, sm_vld_i, dmvm_vld_i, spmm_vld_i};
  assign stage_rdy = {aggr_rdy_i, sm_rdy_i, dmvm_rdy_i, spmm_rdy_i};

  dbg_probe_if i_probe ();

  stage_activity_monitor i_stage_mon (
    .clk         (clk),
    .rst_n       (rst_n),
    .stage_vld_i (stage_vld),
    .stage_rdy_i (stage_rdy),
    .probe       (i_probe)
  );

  feat_write_snooper i_feat_snoop (
    .clk               (clk),
    .rst_n             (rst_n),
    .feat_bram_din_i   (feat_bram_din_i),
    .feat_bram_ena_i   (feat_bram_ena_i),
    .feat_bram_addra_i (feat_bram_addra_i),
    .probe             (i_probe)
  );

  debug_csr_axil i_csr (
    .clk              (clk),
    .rst_n            (rst_n),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .probe            (i_probe)
  );

endmodule

//--- tb_gnn_debug.sv
`timescale 1ns/1ps
`include "gnn_debug_macros.svh"

module tb_gnn_debug;
  import gnn_debug_pkg::*;

  localparam int TIMEOUT_CYCLES = 64;

  logic                          clk;
  logic                          rst_n;
  logic                          spmm_vld_i, spmm_rdy_i, dmvm_vld_i, dmvm_rdy_i;
  logic                          sm_vld_i, sm_rdy_i, aggr_vld_i, aggr_rdy_i;
  logic [`DBG_FEAT_DATA_W-1:0]   feat_bram_din_i;
  logic                          feat_bram_ena_i;
  logic [`DBG_FEAT_ADDR_W-1:0]   feat_bram_addra_i;
  logic [`DBG_AXIL_ADDR_W-1:0]   s_axil_awaddr_i, s_axil_araddr_i;
  logic [`DBG_AXIL_DATA_W-1:0]   s_axil_wdata_i, s_axil_rdata_o;
  logic [`DBG_AXIL_DATA_W/8-1:0] s_axil_wstrb_i;
  logic                          s_axil_awvalid_i, s_axil_awready_o;
  logic                          s_axil_wvalid_i, s_axil_wready_o;
  logic [1:0]                    s_axil_bresp_o, s_axil_rresp_o;
  logic                          s_axil_bvalid_o, s_axil_bready_i;
  logic                          s_axil_arvalid_i, s_axil_arready_o;
  logic                          s_axil_rvalid_o, s_axil_rready_i;
  stage_mask_t                   stage_vld;
  stage_mask_t                   stage_rdy;
  integer                        seed;

  // Reference model state
  stage_mask_t                 m_vld_seen;
  stage_mask_t                 m_rdy_seen;
  xfer_count_t                 m_xfer [`DBG_NUM_STAGES];
  logic                        m_ena_seen;
  logic                        m_high_seen;
  logic [`DBG_CNT_W-1:0]       m_cap0;
  logic [`DBG_CNT_W-1:0]       m_cap1;
  logic [`DBG_FEAT_ADDR_W-1:0] m_watch0;
  logic [`DBG_FEAT_ADDR_W-1:0] m_watch1;

  logic        prev_rvalid, prev_rready, prev_bvalid, prev_bready;
  logic [31:0] prev_rdata;
  logic [1:0]  prev_bresp;

  gnn_debug_top i_gnn_debug_top (.*);

  assign stage_vld = {aggr_vld_i, sm_vld_i, dmvm_vld_i, spmm_vld_i};
  assign stage_rdy = {aggr_rdy_i, sm_rdy_i, dmvm_rdy_i, spmm_rdy_i};

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_stop();
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("** Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
    fail_stop();
  endtask

  task automatic plain_error(input string what);
    $display("Error: %s", what);
    fail_stop();
  endtask

  function automatic int random_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Model follows the probes as the DUT samples them at each edge
  always @(posedge clk) begin
    if (rst_n) begin
      m_vld_seen = m_vld_seen | stage_vld;
      m_rdy_seen = m_rdy_seen | stage_rdy;
      for (int s = 0; s < `DBG_NUM_STAGES; s++) begin
        if (stage_vld[s] && stage_rdy[s]) begin
          m_xfer[s] = m_xfer[s] + 1;
        end
      end
      if (feat_bram_ena_i) begin
        m_ena_seen = 1'b1;
        if (feat_bram_addra_i >= 16'd43328) m_high_seen = 1'b1;
        if (feat_bram_addra_i == m_watch0) m_cap0 = feat_bram_din_i;
        if (feat_bram_addra_i == m_watch1) m_cap1 = feat_bram_din_i;
      end
    end
  end

  // Responses must hold still until the master takes them
  always @(posedge clk) begin
    if (rst_n) begin
      if (prev_rvalid && !prev_rready) begin
        assert (s_axil_rvalid_o) else plain_error("RVALID dropped before RREADY");
        assert (s_axil_rdata_o == prev_rdata)
          else value_error("s_axil_rdata_o", prev_rdata, s_axil_rdata_o);
      end
      if (prev_bvalid && !prev_bready) begin
        assert (s_axil_bvalid_o) else plain_error("BVALID dropped before BREADY");
        assert (s_axil_bresp_o == prev_bresp)
          else value_error("s_axil_bresp_o", 32'(prev_bresp), 32'(s_axil_bresp_o));
      end
      assert (!(s_axil_rvalid_o && s_axil_arready_o))
        else plain_error("ARREADY was high while a read response was pending");
    end
    prev_rvalid <= s_axil_rvalid_o;
    prev_rready <= s_axil_rready_i;
    prev_rdata  <= s_axil_rdata_o;
    prev_bvalid <= s_axil_bvalid_o;
    prev_bready <= s_axil_bready_i;
    prev_bresp  <= s_axil_bresp_o;
  end

  task automatic zero_model();
    m_vld_seen  = '0;
    m_rdy_seen  = '0;
    m_ena_seen  = 1'b0;
    m_high_seen = 1'b0;
    m_cap0      = '0;
    m_cap1      = '0;
    for (int s = 0; s < `DBG_NUM_STAGES; s++) begin
      m_xfer[s] = '0;
    end
  endtask

  task automatic axi_read(input logic [5:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int   waited;
    int   stall;
    logic done;
    @(posedge clk);
    s_axil_araddr_i  <= addr;
    s_axil_arvalid_i <= 1'b1;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = s_axil_arvalid_i && s_axil_arready_o;
      waited++;
      if (!done && waited > TIMEOUT_CYCLES) plain_error("Timeout waiting for ARREADY");
    end
    s_axil_arvalid_i <= 1'b0;
    stall  = random_below(8); // RREADY held low for a random stretch
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      if (stall == 0) s_axil_rready_i <= 1'b1;
      else stall--;
      @(posedge clk);
      done = s_axil_rvalid_o && s_axil_rready_i;
      waited++;
      if (!done && waited > TIMEOUT_CYCLES) plain_error("Timeout waiting for RVALID");
    end
    data = s_axil_rdata_o;
    resp = s_axil_rresp_o;
    s_axil_rready_i <= 1'b0;
  endtask

  task automatic axi_write(input logic [5:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int   waited;
    int   stall;
    logic done;
    @(posedge clk);
    s_axil_awaddr_i  <= addr;
    s_axil_wdata_i   <= data;
    s_axil_wstrb_i   <= strb;
    s_axil_awvalid_i <= 1'b1;
    s_axil_wvalid_i  <= 1'b1;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = s_axil_awready_o && s_axil_wready_o;
      waited++;
      if (!done && waited > TIMEOUT_CYCLES) plain_error("Timeout waiting for AWREADY and WREADY");
    end
    s_axil_awvalid_i <= 1'b0;
    s_axil_wvalid_i  <= 1'b0;
    stall  = random_below(8);
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      if (stall == 0) s_axil_bready_i <= 1'b1;
      else stall--;
      @(posedge clk);
      done = s_axil_bvalid_o && s_axil_bready_i;
      waited++;
      if (!done && waited > TIMEOUT_CYCLES) plain_error("Timeout waiting for BVALID");
    end
    resp = s_axil_bresp_o;
    s_axil_bready_i <= 1'b0;
  endtask

  task automatic write_check(input string name, input logic [5:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] exp_resp);
    logic [1:0] resp;
    axi_write(addr, data, strb, resp);
    assert (resp == exp_resp) else value_error({name, " bresp"}, 32'(exp_resp), 32'(resp));
  endtask

  task automatic check_reg(input string name, input logic [5:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    assert (resp == `DBG_RESP_OKAY) else value_error({name, " rresp"}, 32'h0, 32'(resp));
    assert (data == exp) else value_error(name, exp, data);
  endtask

  task automatic check_all();
    dbg_status_t st;
    // The first read lets the model take in the probe edge it shares with the caller
    check_reg("CONFIG", `DBG_REG_CONFIG, 32'd12);
    st                = '0;
    st.vld_seen       = m_vld_seen;
    st.rdy_seen       = m_rdy_seen;
    st.feat_ena_seen  = m_ena_seen;
    st.feat_high_seen = m_high_seen;
    check_reg("STATUS", `DBG_REG_STATUS, st);
    check_reg("CONTROL", `DBG_REG_CONTROL, 32'h0);
    check_reg("WATCH0", `DBG_REG_WATCH0, 32'(m_watch0));
    check_reg("WATCH1", `DBG_REG_WATCH1, 32'(m_watch1));
    check_reg("CAPTURE0", `DBG_REG_CAPTURE0, m_cap0);
    check_reg("CAPTURE1", `DBG_REG_CAPTURE1, m_cap1);
    for (int s = 0; s < `DBG_NUM_STAGES; s++) begin
      check_reg($sformatf("XFER%0d", s), 6'(`DBG_REG_XFER0 + 4 * s), m_xfer[s]);
    end
  endtask

  task automatic write_watch(input int idx, input logic [31:0] data, input logic [3:0] strb);
    logic [15:0] old;
    old = (idx == 0) ? m_watch0 : m_watch1;
    write_check("WATCH", (idx == 0) ? `DBG_REG_WATCH0 : `DBG_REG_WATCH1, data, strb,
                `DBG_RESP_OKAY);
    if (strb[0]) old[7:0] = data[7:0];
    if (strb[1]) old[15:8] = data[15:8];
    if (idx == 0) m_watch0 = old;
    else m_watch1 = old;
  endtask

  task automatic run_traffic(input int cycles, input stage_mask_t mask);
    logic [31:0] r;
    repeat (cycles) begin
      @(posedge clk);
      r = $random(seed);
      {aggr_vld_i, sm_vld_i, dmvm_vld_i, spmm_vld_i} <= r[3:0] & mask;
      {aggr_rdy_i, sm_rdy_i, dmvm_rdy_i, spmm_rdy_i} <= r[7:4] & mask;
    end
    @(posedge clk);
    {aggr_vld_i, sm_vld_i, dmvm_vld_i, spmm_vld_i} <= '0;
    {aggr_rdy_i, sm_rdy_i, dmvm_rdy_i, spmm_rdy_i} <= '0;
  endtask

  task automatic feat_write(input logic [15:0] addr, input logic [31:0] data, input logic ena);
    @(posedge clk);
    feat_bram_addra_i <= addr;
    feat_bram_din_i   <= data;
    feat_bram_ena_i   <= ena;
    @(posedge clk);
    feat_bram_ena_i   <= 1'b0;
  endtask

  task automatic check_read_error(input logic [5:0] addr);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    assert (resp == `DBG_RESP_SLVERR) else value_error("unmapped rresp", 32'h2, 32'(resp));
  endtask

  initial begin
    seed = 40510;
    rst_n = 1'b0;
    {spmm_vld_i, spmm_rdy_i, dmvm_vld_i, dmvm_rdy_i} = '0;
    {sm_vld_i, sm_rdy_i, aggr_vld_i, aggr_rdy_i} = '0;
    {feat_bram_din_i, feat_bram_ena_i, feat_bram_addra_i} = '0;
    {s_axil_awaddr_i, s_axil_awvalid_i, s_axil_wdata_i, s_axil_wstrb_i, s_axil_wvalid_i} = '0;
    {s_axil_bready_i, s_axil_araddr_i, s_axil_arvalid_i, s_axil_rready_i} = '0;
    zero_model();
    m_watch0 = 16'd1;
    m_watch1 = 16'd2;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (!s_axil_awready_o) else value_error("s_axil_awready_o", 32'h0, 32'(s_axil_awready_o));
    assert (!s_axil_wready_o) else value_error("s_axil_wready_o", 32'h0, 32'(s_axil_wready_o));
    assert (!s_axil_bvalid_o) else value_error("s_axil_bvalid_o", 32'h0, 32'(s_axil_bvalid_o));
    assert (!s_axil_rvalid_o) else value_error("s_axil_rvalid_o", 32'h0, 32'(s_axil_rvalid_o));
    assert (s_axil_arready_o) else value_error("s_axil_arready_o", 32'h1, 32'(s_axil_arready_o));
    check_all();
    run_traffic(300, 4'b0111); // The aggr stage stays quiet here
    check_all();
    run_traffic(200, 4'b1111);
    check_all();
    write_watch(0, 32'h0000_1234, 4'hF);
    write_watch(1, 32'hFFFF_FF78, 4'b0001);
    write_watch(1, 32'h0000_2A00, 4'b0010);
    check_all();
    feat_write(16'h1234, 32'hCAFE_0001, 1'b1);
    feat_write(16'h1234, 32'hCAFE_0002, 1'b1);
    feat_write(16'h2A78, 32'h5EED_0003, 1'b1);
    feat_write(16'h2A78, 32'hDEAD_0004, 1'b0);
    feat_write(16'hB000, 32'h0BAD_0005, 1'b0); // Disabled high write
    check_all();
    feat_write(16'd43327, 32'h0000_0006, 1'b1);
    check_all();
    feat_write(16'd43328, 32'h0000_0007, 1'b1);
    check_all();
    write_watch(1, 32'h0000_1234, 4'b0011);
    feat_write(16'h1234, 32'h1357_9BDF, 1'b1);
    check_all();
    write_check("CONTROL", `DBG_REG_CONTROL, 32'h1, 4'hF, `DBG_RESP_OKAY);
    zero_model();
    check_all();
    run_traffic(100, 4'b1111);
    check_all();
    check_read_error(6'h2C);
    check_read_error(6'h3C);
    write_check("unmapped", 6'h30, 32'hFFFF_FFFF, 4'hF, `DBG_RESP_SLVERR);
    write_check("STATUS", `DBG_REG_STATUS, 32'hFFFF_FFFF, 4'hF, `DBG_RESP_OKAY);
    write_check("CAPTURE0", `DBG_REG_CAPTURE0, 32'h0, 4'hF, `DBG_RESP_OKAY);
    write_check("XFER2", `DBG_REG_XFER2, 32'h0, 4'hF, `DBG_RESP_OKAY);
    write_check("CONTROL", `DBG_REG_CONTROL, 32'h0, 4'hF, `DBG_RESP_OKAY);
    check_all();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- src.f
+incdir+.
gnn_debug_pkg.sv
dbg_probe_if.sv
stage_activity_monitor.sv
feat_write_snooper.sv
debug_csr_axil.sv
gnn_debug_top.sv
tb_gnn_debug.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_gnn_debug \
    -f src.f -o sim_tb \
  && { ./obj_dir/sim_tb > sim.log 2>&1 || true; } \
  && cat sim.log \
  && grep -q "ALL CHECKS PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
